// ==== isp_params.svh ====
`ifndef ISP_PARAMS_SVH
`define ISP_PARAMS_SVH

// ====================
// dram layout
// ====================
`define ISP_DRAM_BASE     32'h0001_0000
`define ISP_FRAME_BYTES   3072
`define ISP_PLANE_BYTES   1024
`define ISP_ROW_BYTES     32

// ====================
// centre patch
// ====================
`define ISP_CENTER_ROW    13
`define ISP_CENTER_COL    13
`define ISP_PATCH         6

// one burst per plane, two beats per patch row
`define ISP_BURST_BEATS   12
`define ISP_PLANES        3

`endif

// ==== isp_axi_pkg.sv ====
package isp_axi_pkg;

    typedef logic [31:0]  axi_addr_t;
    typedef logic [127:0] axi_data_t;
    typedef logic [7:0]   axi_len_t;
    typedef logic [3:0]   axi_id_t;
    typedef logic [2:0]   axi_size_t;
    typedef logic [1:0]   axi_burst_t;

    // 16 bytes per beat
    localparam axi_size_t  AXI_SIZE_16B   = 3'b100;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;

endpackage

// ==== isp_af_pkg.sv ====
package isp_af_pkg;

    // raw byte of one colour plane
    typedef logic [7:0] pixel_t;

    // r + 2g + b, up to 1020
    typedef logic [9:0] gray_sum_t;

    typedef logic [7:0] gray_t;

    // row * 6 + col
    typedef logic [5:0] patch_idx_t;

    typedef logic [1:0] plane_t;

    typedef logic [3:0] beat_idx_t;

    // 60 pairs of up to 255 each
    typedef logic [13:0] diff_sum_t;

endpackage

// ==== af_dram_reader.sv ====
`include "isp_params.svh"

module af_dram_reader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [3:0]             in_pic_no,
    input  logic                   arready,
    input  logic                   rlast,
    input  logic                   rvalid,
    output isp_axi_pkg::axi_addr_t araddr,
    output isp_axi_pkg::axi_len_t  arlen,
    output logic                   arvalid,
    output logic                   rready,
    output logic                   clear,
    output logic                   beat_valid,
    output isp_af_pkg::beat_idx_t  beat_idx,
    output isp_af_pkg::plane_t     plane,
    output logic                   patch_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_DONE
    } state_t;

    localparam isp_af_pkg::plane_t LAST_PLANE = isp_af_pkg::plane_t'(`ISP_PLANES - 1);

    state_t                 state;
    logic [3:0]             pic_q;
    isp_af_pkg::plane_t     plane_q;
    isp_af_pkg::beat_idx_t  beat_q;

    // ====================
    // request and burst sequencing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            pic_q   <= '0;
            plane_q <= '0;
            beat_q  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_valid) begin
                        pic_q   <= in_pic_no;
                        plane_q <= '0;
                        beat_q  <= '0;
                        state   <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (arready) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    // rready is high in this state
                    if (rvalid) begin
                        if (rlast) begin
                            beat_q <= '0;
                            if (plane_q == LAST_PLANE) begin
                                state <= S_DONE;
                            end else begin
                                plane_q <= plane_q + 2'd1;
                                state   <= S_ADDR;
                            end
                        end else begin
                            beat_q <= beat_q + 4'd1;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ====================
    // axi read side
    // ====================
    // plane start plus centre row offset, aligned to 16 bytes
    assign araddr = `ISP_DRAM_BASE
                  + isp_axi_pkg::axi_addr_t'(pic_q) * `ISP_FRAME_BYTES
                  + isp_axi_pkg::axi_addr_t'(plane_q) * `ISP_PLANE_BYTES
                  + `ISP_CENTER_ROW * `ISP_ROW_BYTES;
    assign arlen   = isp_axi_pkg::axi_len_t'(`ISP_BURST_BEATS - 1);
    assign arvalid = (state == S_ADDR);
    assign rready  = (state == S_DATA);

    // buffer side
    assign clear       = (state == S_IDLE) && in_valid;
    assign beat_valid  = rvalid && rready;
    assign beat_idx    = beat_q;
    assign plane       = plane_q;
    assign patch_ready = (state == S_DONE);

endmodule

// ==== af_center_buffer.sv ====
`include "isp_params.svh"

module af_center_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic                   beat_valid,
    input  isp_axi_pkg::axi_data_t beat_data,
    input  isp_af_pkg::beat_idx_t  beat_idx,
    input  isp_af_pkg::plane_t     plane,
    input  isp_af_pkg::patch_idx_t rd_idx_a,
    input  isp_af_pkg::patch_idx_t rd_idx_b,
    output isp_af_pkg::gray_sum_t  rd_sum_a,
    output isp_af_pkg::gray_sum_t  rd_sum_b
);

    localparam int PIXELS     = `ISP_PATCH * `ISP_PATCH;
    localparam int HALF_COLS  = `ISP_PATCH / 2;
    localparam int BEAT_BYTES = 16;
    // first patch byte inside an even beat
    localparam int EVEN_BYTE  = `ISP_CENTER_COL % BEAT_BYTES;

    isp_af_pkg::gray_sum_t  sums [PIXELS];
    isp_af_pkg::pixel_t     px [HALF_COLS];
    isp_af_pkg::gray_sum_t  weighted [HALF_COLS];
    isp_af_pkg::patch_idx_t base_idx;
    logic [2:0]             patch_row;
    logic                   odd_beat;

    assign patch_row = beat_idx[3:1];
    assign odd_beat  = beat_idx[0];
    assign base_idx  = isp_af_pkg::patch_idx_t'(patch_row * `ISP_PATCH
                                                + (odd_beat ? HALF_COLS : 0));

    // odd beat carries the right half of the patch row
    always_comb begin
        for (int k = 0; k < HALF_COLS; k++) begin
            px[k] = odd_beat ? beat_data[8*k +: 8] : beat_data[8*(EVEN_BYTE + k) +: 8];
            // green counts twice
            if (plane == 2'd1) begin
                weighted[k] = isp_af_pkg::gray_sum_t'({px[k], 1'b0});
            end else begin
                weighted[k] = isp_af_pkg::gray_sum_t'(px[k]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIXELS; i++) begin
                sums[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < PIXELS; i++) begin
                sums[i] <= '0;
            end
        end else if (beat_valid) begin
            for (int k = 0; k < HALF_COLS; k++) begin
                sums[base_idx + k] <= sums[base_idx + k] + weighted[k];
            end
        end
    end

    assign rd_sum_a = sums[rd_idx_a];
    assign rd_sum_b = sums[rd_idx_b];

endmodule

// ==== af_contrast.sv ====
`include "isp_params.svh"

module af_contrast (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   patch_ready,
    input  isp_af_pkg::gray_sum_t  rd_sum_a,
    input  isp_af_pkg::gray_sum_t  rd_sum_b,
    output isp_af_pkg::patch_idx_t rd_idx_a,
    output isp_af_pkg::patch_idx_t rd_idx_b,
    output logic                   out_valid,
    output logic [7:0]             out_data
);

    localparam int LAST = `ISP_PATCH - 1;

    logic       active;
    logic       vert;
    logic [2:0] row;
    logic [2:0] col;
    logic [2:0] row_b;
    logic [2:0] col_b;
    logic       last_pair;
    logic       in4;
    logic       in2;

    logic              s1_valid;
    logic              s1_last;
    logic              s1_in4;
    logic              s1_in2;
    isp_af_pkg::gray_t s1_gray_a;
    isp_af_pkg::gray_t s1_gray_b;

    logic              s2_valid;
    logic              s2_last;
    logic              s2_in4;
    logic              s2_in2;
    isp_af_pkg::gray_t s2_diff;

    isp_af_pkg::diff_sum_t acc_2;
    isp_af_pkg::diff_sum_t acc_4;
    isp_af_pkg::diff_sum_t acc_6;
    isp_af_pkg::diff_sum_t avg_2;
    isp_af_pkg::diff_sum_t avg_4;
    isp_af_pkg::diff_sum_t avg_6;
    logic [1:0]            winner;

    function automatic logic in_span(logic [2:0] v, int lo, int hi);
        return (int'(v) >= lo) && (int'(v) <= hi);
    endfunction

    // ====================
    // pair walk
    // ====================
    // 30 horizontal pairs first, then 30 vertical
    assign row_b     = vert ? row + 3'd1 : row;
    assign col_b     = vert ? col : col + 3'd1;
    assign last_pair = vert && (row == 3'(LAST - 1)) && (col == 3'(LAST));

    assign rd_idx_a = isp_af_pkg::patch_idx_t'(row * `ISP_PATCH + col);
    assign rd_idx_b = isp_af_pkg::patch_idx_t'(row_b * `ISP_PATCH + col_b);

    // both pixels must sit inside the window
    assign in4 = in_span(row, 1, 4) && in_span(col, 1, 4)
              && in_span(row_b, 1, 4) && in_span(col_b, 1, 4);
    assign in2 = in_span(row, 2, 3) && in_span(col, 2, 3)
              && in_span(row_b, 2, 3) && in_span(col_b, 2, 3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            vert   <= 1'b0;
            row    <= '0;
            col    <= '0;
        end else if (patch_ready) begin
            active <= 1'b1;
            vert   <= 1'b0;
            row    <= '0;
            col    <= '0;
        end else if (active) begin
            if (!vert && col == 3'(LAST - 1)) begin
                col <= '0;
                if (row == 3'(LAST)) begin
                    row  <= '0;
                    vert <= 1'b1;
                end else begin
                    row <= row + 3'd1;
                end
            end else if (vert && col == 3'(LAST)) begin
                col <= '0;
                row <= row + 3'd1;
                if (last_pair) begin
                    active <= 1'b0;
                end
            end else begin
                col <= col + 3'd1;
            end
        end
    end

    // ====================
    // difference pipeline
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            s2_valid  <= 1'b0;
            s2_last   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= active;
            s1_last   <= active && last_pair;
            s2_valid  <= s1_valid;
            s2_last   <= s1_last;
            out_valid <= s2_last;
        end
    end

    always_ff @(posedge clk) begin
        s1_gray_a <= rd_sum_a[9:2];
        s1_gray_b <= rd_sum_b[9:2];
        s1_in4    <= in4;
        s1_in2    <= in2;
        s2_diff   <= (s1_gray_a > s1_gray_b) ? s1_gray_a - s1_gray_b : s1_gray_b - s1_gray_a;
        s2_in4    <= s1_in4;
        s2_in2    <= s1_in2;
    end

    // window sums, the 2x2 and 4x4 ones nest inside the 6x6
    always_ff @(posedge clk) begin
        if (patch_ready) begin
            acc_2 <= '0;
            acc_4 <= '0;
            acc_6 <= '0;
        end else if (s2_valid) begin
            acc_6 <= acc_6 + isp_af_pkg::diff_sum_t'(s2_diff);
            if (s2_in4) begin
                acc_4 <= acc_4 + isp_af_pkg::diff_sum_t'(s2_diff);
            end
            if (s2_in2) begin
                acc_2 <= acc_2 + isp_af_pkg::diff_sum_t'(s2_diff);
            end
        end
    end

    // ====================
    // decision
    // ====================
    assign avg_2 = acc_2 >> 2;
    assign avg_4 = acc_4 >> 4;
    assign avg_6 = isp_af_pkg::diff_sum_t'(acc_6 / (`ISP_PATCH * `ISP_PATCH));

    // ties go to the smaller window
    always_comb begin
        if (avg_2 >= avg_4 && avg_2 >= avg_6) begin
            winner = 2'd0;
        end else if (avg_4 >= avg_6) begin
            winner = 2'd1;
        end else begin
            winner = 2'd2;
        end
    end

    assign out_data = out_valid ? {6'd0, winner} : 8'd0;

endmodule

// ==== isp_af_top.sv ====
module isp_af_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [3:0]              in_pic_no,
    output logic                    out_valid,
    output logic [7:0]              out_data,
    // axi read address
    output isp_axi_pkg::axi_id_t    arid,
    output isp_axi_pkg::axi_addr_t  araddr,
    output isp_axi_pkg::axi_len_t   arlen,
    output isp_axi_pkg::axi_size_t  arsize,
    output isp_axi_pkg::axi_burst_t arburst,
    output logic                    arvalid,
    input  logic                    arready,
    // axi read data
    input  isp_axi_pkg::axi_id_t    rid,
    input  isp_axi_pkg::axi_data_t  rdata,
    input  logic [1:0]              rresp,
    input  logic                    rlast,
    input  logic                    rvalid,
    output logic                    rready
);

    logic                    clear;
    logic                    beat_valid;
    isp_af_pkg::beat_idx_t   beat_idx;
    isp_af_pkg::plane_t      plane;
    logic                    patch_ready;
    isp_af_pkg::patch_idx_t  rd_idx_a;
    isp_af_pkg::patch_idx_t  rd_idx_b;
    isp_af_pkg::gray_sum_t   rd_sum_a;
    isp_af_pkg::gray_sum_t   rd_sum_b;

    // fixed read fields, single id
    assign arid    = '0;
    assign arsize  = isp_axi_pkg::AXI_SIZE_16B;
    assign arburst = isp_axi_pkg::AXI_BURST_INCR;

    af_dram_reader u_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_pic_no   (in_pic_no),
        .arready     (arready),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arvalid     (arvalid),
        .rready      (rready),
        .clear       (clear),
        .beat_valid  (beat_valid),
        .beat_idx    (beat_idx),
        .plane       (plane),
        .patch_ready (patch_ready)
    );

    af_center_buffer u_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .beat_valid (beat_valid),
        .beat_data  (rdata),
        .beat_idx   (beat_idx),
        .plane      (plane),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b),
        .rd_sum_a   (rd_sum_a),
        .rd_sum_b   (rd_sum_b)
    );

    af_contrast u_contrast (
        .clk         (clk),
        .rst_n       (rst_n),
        .patch_ready (patch_ready),
        .rd_sum_a    (rd_sum_a),
        .rd_sum_b    (rd_sum_b),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

// ==== tb_dram_model.sv ====
`include "isp_params.svh"

module tb_dram_model (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    gap_en,
    input  isp_axi_pkg::axi_addr_t  araddr,
    input  isp_axi_pkg::axi_len_t   arlen,
    input  logic                    arvalid,
    output logic                    arready,
    output isp_axi_pkg::axi_id_t    rid,
    output isp_axi_pkg::axi_data_t  rdata,
    output logic [1:0]              rresp,
    output logic                    rlast,
    output logic                    rvalid,
    input  logic                    rready
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_BYTES  = 16 * `ISP_FRAME_BYTES;
    localparam int BEAT_BYTES = 16;

    // byte 0 sits at ISP_DRAM_BASE
    logic [7:0]             mem [MEM_BYTES];
    isp_axi_pkg::axi_addr_t next_addr;
    int                     beats_left;

    function automatic isp_axi_pkg::axi_data_t read_beat(isp_axi_pkg::axi_addr_t addr);
        isp_axi_pkg::axi_data_t beat;
        int                     off;
        beat = '0;
        off  = int'(addr - `ISP_DRAM_BASE);
        if (off >= 0 && off + BEAT_BYTES <= MEM_BYTES) begin
            for (int k = 0; k < BEAT_BYTES; k++) begin
                beat[8*k +: 8] = mem[off + k];
            end
        end
        return beat;
    endfunction

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8);
        end
    end

    assign rid   = '0;
    assign rresp = 2'b00;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            rdata      <= '0;
            next_addr  <= '0;
            beats_left <= 0;
        end else begin
            // ====================
            // address channel
            // ====================
            if (arvalid && arready) begin
                next_addr  <= araddr;
                beats_left <= int'(arlen) + 1;
                arready    <= 1'b0;
            end else if (beats_left == 0 && !rvalid) begin
                arready <= !(gap_en && $urandom_range(0, 2) == 0);
            end

            // ====================
            // data channel
            // ====================
            // a beat stays put until it is taken
            if (!rvalid || rready) begin
                if (beats_left != 0 && !(gap_en && $urandom_range(0, 3) == 0)) begin
                    rvalid     <= 1'b1;
                    rdata      <= read_beat(next_addr);
                    rlast      <= (beats_left == 1);
                    next_addr  <= next_addr + BEAT_BYTES;
                    beats_left <= beats_left - 1;
                end else begin
                    rvalid <= 1'b0;
                    rlast  <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== tb_isp_af.sv ====
`include "isp_params.svh"

module tb_isp_af;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD    = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_REQUESTS   = 23;
    localparam int REQUEST_CYCLES = 3000;
    // 63 cycles after patch_ready, which trails the last beat by one
    localparam int RESULT_DELAY   = 64;
    localparam int P              = `ISP_PATCH;
    // 16-byte beats and incrementing bursts in axi encoding
    localparam int AR_SIZE_16B    = 4;
    localparam int AR_BURST_INCR  = 1;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic [3:0]              in_pic_no;
    logic                    out_valid;
    logic [7:0]              out_data;
    isp_axi_pkg::axi_id_t    arid;
    isp_axi_pkg::axi_addr_t  araddr;
    isp_axi_pkg::axi_len_t   arlen;
    isp_axi_pkg::axi_size_t  arsize;
    isp_axi_pkg::axi_burst_t arburst;
    logic                    arvalid;
    logic                    arready;
    isp_axi_pkg::axi_id_t    rid;
    isp_axi_pkg::axi_data_t  rdata;
    logic [1:0]              rresp;
    logic                    rlast;
    logic                    rvalid;
    logic                    rready;
    logic                    gap_en;

    int                      errors;
    int                      checks;
    int                      cycle_no;
    int                      burst_no;
    int                      last_beat_cycle;
    logic                    req_busy;
    logic [3:0]              req_pic;
    logic                    result_seen;
    logic [7:0]              result_data;
    logic                    ar_pending;
    isp_axi_pkg::axi_addr_t  ar_addr_q;
    isp_axi_pkg::axi_len_t   ar_len_q;

    isp_af_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pic_no (in_pic_no),
        .out_valid (out_valid),
        .out_data  (out_data),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    tb_dram_model dram (
        .clk     (clk),
        .rst_n   (rst_n),
        .gap_en  (gap_en),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
    end

    // ====================
    // checks and reference
    // ====================
    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_condition(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    function automatic int byte_offset(int pic, int plane, int prow, int pcol);
        return pic * `ISP_FRAME_BYTES + plane * `ISP_PLANE_BYTES
             + (`ISP_CENTER_ROW + prow) * `ISP_ROW_BYTES + `ISP_CENTER_COL + pcol;
    endfunction

    function automatic int burst_address(int pic, int plane);
        return `ISP_DRAM_BASE + pic * `ISP_FRAME_BYTES + plane * `ISP_PLANE_BYTES
             + `ISP_CENTER_ROW * `ISP_ROW_BYTES;
    endfunction

    function automatic logic inside_window(int r, int c, int r2, int c2, int lo, int hi);
        return r >= lo && r <= hi && c >= lo && c <= hi
            && r2 >= lo && r2 <= hi && c2 >= lo && c2 <= hi;
    endfunction

    function automatic int expected_window(int pic);
        int gray [P][P];
        int s2;
        int s4;
        int s6;
        int d;
        int r2;
        int c2;
        s2 = 0;
        s4 = 0;
        s6 = 0;
        for (int r = 0; r < P; r++) begin
            for (int c = 0; c < P; c++) begin
                gray[r][c] = (int'(dram.mem[byte_offset(pic, 0, r, c)])
                            + 2 * int'(dram.mem[byte_offset(pic, 1, r, c)])
                            + int'(dram.mem[byte_offset(pic, 2, r, c)])) / 4;
            end
        end
        // dir 0 pairs with the right neighbour, dir 1 with the one below
        for (int dir = 0; dir < 2; dir++) begin
            for (int r = 0; r < P; r++) begin
                for (int c = 0; c < P; c++) begin
                    r2 = r + dir;
                    c2 = c + 1 - dir;
                    if (r2 < P && c2 < P) begin
                        d = gray[r][c] - gray[r2][c2];
                        if (d < 0) begin
                            d = -d;
                        end
                        s6 += d;
                        if (inside_window(r, c, r2, c2, 1, 4)) begin
                            s4 += d;
                        end
                        if (inside_window(r, c, r2, c2, 2, 3)) begin
                            s2 += d;
                        end
                    end
                end
            end
        end
        if (s2 / 4 >= s4 / 16 && s2 / 4 >= s6 / 36) begin
            return 0;
        end else if (s4 / 16 >= s6 / 36) begin
            return 1;
        end
        return 2;
    endfunction

    // bus monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (!out_valid) begin
                check_value("out_data", int'(out_data), 0);
            end
            if (!req_busy) begin
                check_condition(!arvalid && !rready && !out_valid,
                                "arvalid, rready or out_valid high with no request in progress");
                if (in_valid) begin
                    req_busy   = 1'b1;
                    req_pic    = in_pic_no;
                    burst_no   = 0;
                    ar_pending = 1'b0;
                end
            end else begin
                if (ar_pending) begin
                    check_condition(arvalid && araddr == ar_addr_q && arlen == ar_len_q,
                                    "arvalid dropped or address changed before arready");
                end
                if (arvalid && arready) begin
                    check_value("araddr", int'(araddr), burst_address(int'(req_pic), burst_no));
                    check_value("arlen", int'(arlen), `ISP_BURST_BEATS - 1);
                    check_value("arid", int'(arid), 0);
                    check_value("arsize", int'(arsize), AR_SIZE_16B);
                    check_value("arburst", int'(arburst), AR_BURST_INCR);
                    burst_no++;
                end
                ar_pending = arvalid && !arready;
                ar_addr_q  = araddr;
                ar_len_q   = arlen;
                if (rvalid && rready && rlast && burst_no == `ISP_PLANES) begin
                    last_beat_cycle = cycle_no;
                end
                if (out_valid) begin
                    check_value("out_valid latency", cycle_no - last_beat_cycle, RESULT_DELAY);
                    result_data = out_data;
                    result_seen = 1'b1;
                    req_busy    = 1'b0;
                end
            end
        end
    end

    // ====================
    // stimulus
    // ====================
    task automatic set_pixel(input int pic, input int prow, input int pcol,
                             input int r, input int g, input int b);
        dram.mem[byte_offset(pic, 0, prow, pcol)] = 8'(r);
        dram.mem[byte_offset(pic, 1, prow, pcol)] = 8'(g);
        dram.mem[byte_offset(pic, 2, prow, pcol)] = 8'(b);
    endtask

    task automatic run_request(input int pic, input int expected);
        result_seen = 1'b0;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_pic_no <= 4'(pic);
        @(posedge clk);
        in_valid  <= 1'b0;
        wait (result_seen);
        check_value("out_data", int'(result_data), expected);
        repeat (4) @(posedge clk);
    endtask

    task automatic test_idle_after_reset;
        repeat (20) begin
            @(negedge clk);
            check_condition(!arvalid && !rready && !out_valid && out_data == 8'd0,
                            "DUT active after reset with no request");
        end
    endtask

    task automatic test_flat_picture;
        for (int r = 0; r < P; r++) begin
            for (int c = 0; c < P; c++) begin
                set_pixel(3, r, c, 40, 90, 10);
            end
        end
        run_request(3, 0);
    endtask

    task automatic test_ring_edges;
        // bright border ring, dark 4x4 core
        for (int r = 0; r < P; r++) begin
            for (int c = 0; c < P; c++) begin
                if (r == 0 || r == P - 1 || c == 0 || c == P - 1) begin
                    set_pixel(7, r, c, 200, 200, 200);
                end else begin
                    set_pixel(7, r, c, 0, 0, 0);
                end
            end
        end
        run_request(7, 2);
    endtask

    task automatic test_center_edge;
        for (int r = 0; r < P; r++) begin
            for (int c = 0; c < P; c++) begin
                set_pixel(9, r, c, 0, 0, 0);
            end
        end
        set_pixel(9, 2, 2, 100, 100, 100);
        run_request(9, 0);
    endtask

    task automatic test_random_pictures;
        for (int p = 0; p < 16; p++) begin
            for (int r = 0; r < P; r++) begin
                for (int c = 0; c < P; c++) begin
                    set_pixel(p, r, c, $urandom_range(0, 255), $urandom_range(0, 255),
                              $urandom_range(0, 255));
                end
            end
            run_request(p, expected_window(p));
        end
    endtask

    task automatic test_ready_gaps;
        gap_en <= 1'b1;
        for (int p = 0; p < 4; p++) begin
            run_request(p, expected_window(p));
        end
        gap_en <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h7e20b6be));
        clk             = 1'b0;
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_pic_no       = 4'd0;
        gap_en          = 1'b0;
        errors          = 0;
        checks          = 0;
        cycle_no        = 0;
        burst_no        = 0;
        last_beat_cycle = 0;
        req_busy        = 1'b0;
        req_pic         = 4'd0;
        result_seen     = 1'b0;
        result_data     = 8'd0;
        ar_pending      = 1'b0;
        ar_addr_q       = '0;
        ar_len_q        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_idle_after_reset();
        test_flat_picture();
        test_ring_edges();
        test_center_edge();
        test_random_pictures();
        test_ready_gaps();
        repeat (10) @(posedge clk);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_REQUESTS * REQUEST_CYCLES) @(posedge clk);
        errors++;
        $display("watchdog: run did not finish within %0d cycles",
                 RESET_CYCLES + NUM_REQUESTS * REQUEST_CYCLES);
        $display("summary: %0d checks, %0d errors", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
isp_axi_pkg.sv
isp_af_pkg.sv
af_dram_reader.sv
af_center_buffer.sv
af_contrast.sv
isp_af_top.sv
tb_dram_model.sv
tb_isp_af.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := tb_isp_af
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) isp_params.svh $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
